// File: rtl/wakeupPkg.sv
// ============================
// Widths, payload structs and register map of the wakeup stage
// Issue queue and active list are both 16 entries
// AXI4-Lite offsets are full byte addresses, word aligned
// ============================

package wakeupPkg;

    localparam int IqEntries = 16;
    localparam int ActiveListEntries = 16;
    localparam int IntWidth = 2;
    localparam int MemWidth = 1;
    localparam int IssueWidth = IntWidth + MemWidth;

    localparam int IqIdxWidth = $clog2(IqEntries);
    localparam int AlIdxWidth = $clog2(ActiveListEntries);

    localparam int AxiAddrWidth = 8;
    localparam int AxiDataWidth = 32;

    // Register map
    localparam logic [AxiAddrWidth-1:0] RegFlushHead = 8'h00;
    localparam logic [AxiAddrWidth-1:0] RegFlushTail = 8'h04;
    localparam logic [AxiAddrWidth-1:0] RegFlushAll = 8'h08;
    localparam logic [AxiAddrWidth-1:0] RegControl = 8'h0C;
    localparam logic [AxiAddrWidth-1:0] RegStatus = 8'h10;

    localparam logic [1:0] RespOkay = 2'd0;
    localparam logic [1:0] RespSlvErr = 2'd2;

    typedef logic [IqIdxWidth-1:0] iqIdxT;
    typedef logic [IqEntries-1:0] iqOneHotT;
    typedef logic [AlIdxWidth-1:0] alIdxT;

    // One selected op, also the layout of a delay-line stage
    typedef struct packed {
        logic valid;
        iqIdxT ptr;
        iqOneHotT depVector;
        alIdxT activeListPtr;
    } issueSlotT;

    typedef struct packed {
        logic wakeup;
        iqIdxT ptr;
        iqOneHotT depVector;
    } wakeupT;

    // Entry release towards the issue queue
    typedef struct packed {
        logic valid;
        iqIdxT ptr;
    } releaseT;

    typedef struct packed {
        alIdxT head;
        alIdxT tail;
        logic flushAll;
    } flushRangeT;

    typedef struct packed {
        logic awvalid;
        logic [AxiAddrWidth-1:0] awaddr;
        logic wvalid;
        logic [AxiDataWidth-1:0] wdata;
        logic [AxiDataWidth/8-1:0] wstrb;
        logic bready;
        logic arvalid;
        logic [AxiAddrWidth-1:0] araddr;
        logic rready;
    } axiLiteReqT;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [AxiDataWidth-1:0] rdata;
        logic [1:0] rresp;
    } axiLiteRspT;

    // Head equal to tail covers nothing unless flushAll is set
    function automatic logic inFlushRange(flushRangeT range, alIdxT ptr);
        if (range.flushAll) begin
            return 1'b1;
        end
        if (range.head <= range.tail) begin
            return (ptr >= range.head) && (ptr < range.tail);
        end
        // Wrapped range
        return (ptr >= range.head) || (ptr < range.tail);
    endfunction

endpackage

// File: rtl/wakeupLane.sv
// ============================
// One pipe class of the wakeup stage
// Latency must be at least 1
// At latency 1 outputs are gated by stall
// ============================

`timescale 1ns/1ps

module wakeupLane #(
    parameter int Width = 1,
    parameter int Latency = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  wakeupPkg::issueSlotT [Width-1:0] select,
    input  wakeupPkg::iqOneHotT flushIqEntry,
    input  wakeupPkg::flushRangeT flushRange,
    input  logic selRecover,
    input  logic fullRecover,
    output wakeupPkg::wakeupT [Width-1:0] wakeup,
    output wakeupPkg::releaseT [Width-1:0] releaseEntry,
    output logic flushPending
);

    import wakeupPkg::*;

    localparam int CntWidth = $clog2(Latency + 1);
    localparam bit StallGated = (Latency == 1);

    // Stage 0 is the output, stage Latency-1 takes selected ops
    issueSlotT stage [Width][Latency];
    issueSlotT nextStage [Width][Latency];
    issueSlotT incoming [Width];

    logic [CntWidth-1:0] flushCnt;
    flushRangeT rangeQ;
    logic flushed [Width];
    logic outGate;

    // Ops whose entry is flushed at selection enter invalid
    always_comb begin
        for (int i = 0; i < Width; i++) begin
            incoming[i] = select[i];
            incoming[i].valid = select[i].valid && !flushIqEntry[select[i].ptr];
        end
    end

    if (Latency > 1) begin : gDeep
        always_comb begin
            for (int i = 0; i < Width; i++) begin
                for (int j = 0; j < Latency; j++) begin
                    nextStage[i][j] = stage[i][j];
                end
                if (!stall) begin
                    for (int j = 0; j < Latency - 1; j++) begin
                        nextStage[i][j] = stage[i][j+1];
                    end
                    nextStage[i][Latency-1] = incoming[i];
                end else begin
                    // Input stage holds, lower stages drain, a bubble follows it
                    for (int j = 0; j < Latency - 2; j++) begin
                        nextStage[i][j] = stage[i][j+1];
                    end
                    nextStage[i][Latency-2].valid = 1'b0;
                    nextStage[i][Latency-2].depVector = '0;
                end
            end
        end
    end else begin : gShallow
        // Single stage freezes while stalled
        always_comb begin
            for (int i = 0; i < Width; i++) begin
                nextStage[i][0] = stall ? stage[i][0] : incoming[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < Width; i++) begin
                for (int j = 0; j < Latency; j++) begin
                    stage[i][j].valid <= 1'b0;
                end
            end
        end else begin
            for (int i = 0; i < Width; i++) begin
                for (int j = 0; j < Latency; j++) begin
                    stage[i][j] <= nextStage[i][j];
                    if (fullRecover) begin
                        stage[i][j].valid <= 1'b0;
                    end
                end
            end
        end
    end

    // Window in which a flushed op may still sit in the delay line
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flushCnt <= '0;
        end else if (selRecover) begin
            flushCnt <= CntWidth'(Latency);
        end else if (flushCnt == CntWidth'(Latency)) begin
            if (!stall) begin
                flushCnt <= flushCnt - 1'b1;
            end
        end else if (flushCnt != '0) begin
            flushCnt <= flushCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (selRecover) begin
            rangeQ <= flushRange;
        end
    end

    assign flushPending = (flushCnt != '0);
    assign outGate = !(StallGated && stall);

    always_comb begin
        for (int i = 0; i < Width; i++) begin
            flushed[i] = flushPending && inFlushRange(rangeQ, stage[i][0].activeListPtr);
            wakeup[i].wakeup = stage[i][0].valid && !flushed[i] && outGate;
            wakeup[i].ptr = stage[i][0].ptr;
            wakeup[i].depVector = outGate ? stage[i][0].depVector : '0;
            releaseEntry[i].valid = stage[i][0].valid && outGate;
            releaseEntry[i].ptr = stage[i][0].ptr;
        end
    end

    for (genvar i = 0; i < Width; i++) begin : gCheck
        assert property (@(posedge clk) disable iff (!rstN)
            wakeup[i].wakeup |-> releaseEntry[i].valid)
            else $error("wakeup without release on slot %0d", i);
    end

endmodule

// File: rtl/recoveryRegs.sv
// ============================
// AXI4-Lite register block for recovery control
// One outstanding write and one outstanding read
// Byte lane 0 of wstrb enables a register write
// ============================

`timescale 1ns/1ps

module recoveryRegs (
    input  logic clk,
    input  logic rstN,
    input  wakeupPkg::axiLiteReqT axiReq,
    output wakeupPkg::axiLiteRspT axiRsp,
    input  logic flushPending,
    output wakeupPkg::flushRangeT flushRange,
    output logic selRecover,
    output logic fullRecover
);

    import wakeupPkg::*;

    logic writeAccept;
    logic readAccept;
    logic writeMapped;
    logic readMapped;
    logic [AxiDataWidth-1:0] readData;

    logic bvalidQ;
    logic rvalidQ;
    logic [1:0] brespQ;
    logic [1:0] rrespQ;
    logic [AxiDataWidth-1:0] rdataQ;

    alIdxT headQ;
    alIdxT tailQ;
    logic flushAllQ;
    logic selPulseQ;
    logic fullPulseQ;

    assign writeAccept = axiReq.awvalid && axiReq.wvalid && !bvalidQ;
    assign readAccept = axiReq.arvalid && !rvalidQ;

    always_comb begin
        case (axiReq.awaddr)
            RegFlushHead, RegFlushTail, RegFlushAll, RegControl, RegStatus: begin
                writeMapped = 1'b1;
            end
            default: writeMapped = 1'b0;
        endcase
    end

    // Control reads back as zero
    always_comb begin
        readMapped = 1'b1;
        readData = '0;
        case (axiReq.araddr)
            RegFlushHead: readData = AxiDataWidth'(headQ);
            RegFlushTail: readData = AxiDataWidth'(tailQ);
            RegFlushAll: readData = AxiDataWidth'(flushAllQ);
            RegControl: readData = '0;
            RegStatus: readData = AxiDataWidth'(flushPending);
            default: readMapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headQ <= '0;
            tailQ <= '0;
            flushAllQ <= 1'b0;
            selPulseQ <= 1'b0;
            fullPulseQ <= 1'b0;
            bvalidQ <= 1'b0;
            rvalidQ <= 1'b0;
        end else begin
            selPulseQ <= 1'b0;
            fullPulseQ <= 1'b0;
            if (writeAccept && axiReq.wstrb[0]) begin
                case (axiReq.awaddr)
                    RegFlushHead: headQ <= alIdxT'(axiReq.wdata);
                    RegFlushTail: tailQ <= alIdxT'(axiReq.wdata);
                    RegFlushAll: flushAllQ <= axiReq.wdata[0];
                    RegControl: begin
                        // Full recovery wins over selective
                        fullPulseQ <= axiReq.wdata[1];
                        selPulseQ <= axiReq.wdata[0] && !axiReq.wdata[1];
                    end
                    default: ;
                endcase
            end
            if (writeAccept) begin
                bvalidQ <= 1'b1;
            end else if (axiReq.bready) begin
                bvalidQ <= 1'b0;
            end
            if (readAccept) begin
                rvalidQ <= 1'b1;
            end else if (axiReq.rready) begin
                rvalidQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            brespQ <= writeMapped ? RespOkay : RespSlvErr;
        end
        if (readAccept) begin
            rdataQ <= readData;
            rrespQ <= readMapped ? RespOkay : RespSlvErr;
        end
    end

    always_comb begin
        axiRsp.awready = writeAccept;
        axiRsp.wready = writeAccept;
        axiRsp.bvalid = bvalidQ;
        axiRsp.bresp = brespQ;
        axiRsp.arready = readAccept;
        axiRsp.rvalid = rvalidQ;
        axiRsp.rdata = rdataQ;
        axiRsp.rresp = rrespQ;
    end

    assign flushRange = '{head: headQ, tail: tailQ, flushAll: flushAllQ};
    assign selRecover = selPulseQ;
    assign fullRecover = fullPulseQ;

    assert property (@(posedge clk) disable iff (!rstN)
        bvalidQ && !axiReq.bready |=> bvalidQ)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (!rstN)
        rvalidQ && !axiReq.rready |=> rvalidQ)
        else $error("rvalid dropped before rready");

    assert property (@(posedge clk) disable iff (!rstN)
        !(selPulseQ && fullPulseQ))
        else $error("selective and full recovery together");

endmodule

// File: rtl/wakeupSched.sv
// ============================
// Wakeup stage top level
// Integer slots come first, memory slots after
// Adds no latency beyond the lanes
// ============================

`timescale 1ns/1ps

module wakeupSched #(
    parameter int IntLatency = 1,
    parameter int MemLatency = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  wakeupPkg::issueSlotT [wakeupPkg::IssueWidth-1:0] select,
    input  wakeupPkg::iqOneHotT flushIqEntry,
    output wakeupPkg::wakeupT [wakeupPkg::IssueWidth-1:0] wakeup,
    output wakeupPkg::releaseT [wakeupPkg::IssueWidth-1:0] releaseEntry,
    input  wakeupPkg::axiLiteReqT axiReq,
    output wakeupPkg::axiLiteRspT axiRsp
);

    import wakeupPkg::*;

    flushRangeT flushRange;
    logic selRecover;
    logic fullRecover;
    logic intPending;
    logic memPending;
    logic flushPending;

    wakeupLane #(
        .Width(IntWidth),
        .Latency(IntLatency)
    ) intLane (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .select(select[IntWidth-1:0]),
        .flushIqEntry(flushIqEntry),
        .flushRange(flushRange),
        .selRecover(selRecover),
        .fullRecover(fullRecover),
        .wakeup(wakeup[IntWidth-1:0]),
        .releaseEntry(releaseEntry[IntWidth-1:0]),
        .flushPending(intPending)
    );

    wakeupLane #(
        .Width(MemWidth),
        .Latency(MemLatency)
    ) memLane (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .select(select[IssueWidth-1:IntWidth]),
        .flushIqEntry(flushIqEntry),
        .flushRange(flushRange),
        .selRecover(selRecover),
        .fullRecover(fullRecover),
        .wakeup(wakeup[IssueWidth-1:IntWidth]),
        .releaseEntry(releaseEntry[IssueWidth-1:IntWidth]),
        .flushPending(memPending)
    );

    // Status shows a flushed op may remain in either lane
    assign flushPending = intPending || memPending;

    recoveryRegs regs (
        .clk(clk),
        .rstN(rstN),
        .axiReq(axiReq),
        .axiRsp(axiRsp),
        .flushPending(flushPending),
        .flushRange(flushRange),
        .selRecover(selRecover),
        .fullRecover(fullRecover)
    );

endmodule

// File: verification/axiTasks.svh
// ==============================
// AXI4-Lite manager tasks for the testbench
// Expects clk, axiReq, axiRsp, wrAccSeen and rdAccSeen in scope
// bready and rready stay high, so one access is open at a time
// ==============================

`ifndef AXI_TASKS_SVH
`define AXI_TASKS_SVH

// Address and data go out together, response is taken mid-cycle
task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                        output logic [1:0] resp);
    @(negedge clk);
    axiReq.awvalid = 1'b1;
    axiReq.awaddr = addr;
    axiReq.wvalid = 1'b1;
    axiReq.wdata = data;
    axiReq.wstrb = 4'hF;
    do begin
        @(negedge clk);
    end while (!wrAccSeen);
    axiReq.awvalid = 1'b0;
    axiReq.wvalid = 1'b0;
    while (!axiRsp.bvalid) begin
        @(negedge clk);
    end
    resp = axiRsp.bresp;
endtask

task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                       output logic [1:0] resp);
    @(negedge clk);
    axiReq.arvalid = 1'b1;
    axiReq.araddr = addr;
    do begin
        @(negedge clk);
    end while (!rdAccSeen);
    axiReq.arvalid = 1'b0;
    while (!axiRsp.rvalid) begin
        @(negedge clk);
    end
    data = axiRsp.rdata;
    resp = axiRsp.rresp;
endtask

`endif

// File: verification/wakeupTb.sv
// ==============================
// Testbench for wakeupSched at default latencies 1 and 2
// A reference pipeline built from the lane rules feeds the assertions
// Stimulus changes on the falling edge only
// ==============================

`timescale 1ns/1ps

module wakeupTb;

    import wakeupPkg::*;

    // Roughly 250 cycles of tests, with generous margin
    localparam int MaxCycles = 2000;

    logic clk;
    logic rstN;
    logic stall;
    issueSlotT [IssueWidth-1:0] select;
    iqOneHotT flushIqEntry;
    wakeupT [IssueWidth-1:0] wakeup;
    releaseT [IssueWidth-1:0] releaseEntry;
    axiLiteReqT axiReq;
    axiLiteRspT axiRsp;

    int seed = 95;
    int errCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;
    bit driveOps = 0;
    bit stallMode = 0;
    bit maskMode = 0;
    logic wrAccSeen;
    logic rdAccSeen;

    // Reference state
    issueSlotT intRef [IntWidth];
    issueSlotT memS1;
    issueSlotT memS0;
    logic [1:0] intCnt;
    logic [1:0] memCnt;
    logic pendFull;
    logic pendSel;
    alIdxT tbHead;
    alIdxT tbTail;
    logic tbAll;
    flushRangeT refRange;
    logic ctlWrite;
    issueSlotT expSlot [IssueWidth];
    logic expRel [IssueWidth];
    logic expWake [IssueWidth];

    `include "axiTasks.svh"

    wakeupSched DUT (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .select(select),
        .flushIqEntry(flushIqEntry),
        .wakeup(wakeup),
        .releaseEntry(releaseEntry),
        .axiReq(axiReq),
        .axiRsp(axiRsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic bit rangeHit(flushRangeT r, alIdxT p);
        if (r.flushAll) return 1'b1;
        if (r.head <= r.tail) return (p >= r.head) && (p < r.tail);
        return (p >= r.head) || (p < r.tail);
    endfunction

    // Selection mask kills the op on entry
    function automatic issueSlotT maskOp(issueSlotT op, iqOneHotT mask);
        issueSlotT res;
        res = op;
        res.valid = op.valid && !mask[op.ptr];
        return res;
    endfunction

    task automatic reportValue(string name, int slot, int got, int exp);
        errCount++;
        $display("ERR %0t %s[%0d] got %0h exp %0h", $time, name, slot, got, exp);
    endtask

    assign ctlWrite = axiRsp.awready && (axiReq.awaddr == RegControl) && axiReq.wstrb[0];

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < IntWidth; i++) intRef[i] <= '0;
            memS1 <= '0;
            memS0 <= '0;
            intCnt <= '0;
            memCnt <= '0;
            pendFull <= 1'b0;
            pendSel <= 1'b0;
            tbHead <= '0;
            tbTail <= '0;
            tbAll <= 1'b0;
            refRange <= '0;
            wrAccSeen <= 1'b0;
            rdAccSeen <= 1'b0;
        end else begin
            wrAccSeen <= axiRsp.awready;
            rdAccSeen <= axiRsp.arready;
            for (int i = 0; i < IntWidth; i++) begin
                if (!stall) intRef[i] <= maskOp(select[i], flushIqEntry);
                if (pendFull) intRef[i].valid <= 1'b0;
            end
            if (!stall) begin
                memS1 <= maskOp(select[IntWidth], flushIqEntry);
                memS0 <= memS1;
            end else begin
                memS0 <= '0;
            end
            if (pendFull) begin
                memS1.valid <= 1'b0;
                memS0.valid <= 1'b0;
            end
            // Window counters, held at full value while stalled
            if (pendSel) intCnt <= 2'd1;
            else if (intCnt != 0 && !stall) intCnt <= intCnt - 1'b1;
            if (pendSel) memCnt <= 2'd2;
            else if (memCnt == 2'd2 && !stall) memCnt <= 2'd1;
            else if (memCnt == 2'd1) memCnt <= 2'd0;
            if (pendSel) refRange <= '{head: tbHead, tail: tbTail, flushAll: tbAll};
            pendFull <= ctlWrite && axiReq.wdata[1];
            pendSel <= ctlWrite && axiReq.wdata[0] && !axiReq.wdata[1];
            if (axiRsp.awready && axiReq.wstrb[0]) begin
                if (axiReq.awaddr == RegFlushHead) tbHead <= alIdxT'(axiReq.wdata[3:0]);
                if (axiReq.awaddr == RegFlushTail) tbTail <= alIdxT'(axiReq.wdata[3:0]);
                if (axiReq.awaddr == RegFlushAll) tbAll <= axiReq.wdata[0];
            end
        end
    end

    always_comb begin
        for (int s = 0; s < IssueWidth; s++) begin
            if (s < IntWidth) begin
                expSlot[s] = intRef[s];
                expRel[s] = intRef[s].valid && !stall;
                expWake[s] = expRel[s] && !(intCnt != 0 && rangeHit(refRange, intRef[s].activeListPtr));
            end else begin
                expSlot[s] = memS0;
                expRel[s] = memS0.valid;
                expWake[s] = expRel[s] && !(memCnt != 0 && rangeHit(refRange, memS0.activeListPtr));
            end
        end
    end

    for (genvar s = 0; s < IssueWidth; s++) begin : gCheck
        assert property (@(posedge clk) disable iff (!rstN)
            releaseEntry[s].valid == expRel[s])
            else reportValue("releaseEntry.valid", s, $sampled(releaseEntry[s].valid),
                             $sampled(expRel[s]));
        assert property (@(posedge clk) disable iff (!rstN)
            expRel[s] |-> releaseEntry[s].ptr == expSlot[s].ptr)
            else reportValue("releaseEntry.ptr", s, $sampled(releaseEntry[s].ptr),
                             $sampled(expSlot[s].ptr));
        assert property (@(posedge clk) disable iff (!rstN)
            wakeup[s].wakeup == expWake[s])
            else reportValue("wakeup.wakeup", s, $sampled(wakeup[s].wakeup),
                             $sampled(expWake[s]));
        assert property (@(posedge clk) disable iff (!rstN)
            expWake[s] |-> wakeup[s].ptr == expSlot[s].ptr)
            else reportValue("wakeup.ptr", s, $sampled(wakeup[s].ptr),
                             $sampled(expSlot[s].ptr));
        assert property (@(posedge clk) disable iff (!rstN)
            expWake[s] |-> wakeup[s].depVector == expSlot[s].depVector)
            else reportValue("wakeup.depVector", s, $sampled(wakeup[s].depVector),
                             $sampled(expSlot[s].depVector));
        if (s < IntWidth) begin : gInt
            assert property (@(posedge clk) disable iff (!rstN)
                stall |-> wakeup[s].depVector == '0)
                else reportValue("wakeup.depVector", s, $sampled(wakeup[s].depVector), 0);
        end
    end

    // Write address and write data are accepted on the same cycle
    assert property (@(posedge clk) disable iff (!rstN)
        axiRsp.wready == axiRsp.awready)
        else reportValue("axiRsp.wready", 0, $sampled(axiRsp.wready),
                         $sampled(axiRsp.awready));

    // Random ops, stall and selection mask
    always @(negedge clk) begin
        for (int s = 0; s < IssueWidth; s++) begin
            select[s].valid = driveOps ? 1'($random(seed)) : 1'b0;
            select[s].ptr = iqIdxT'($random(seed));
            select[s].depVector = iqOneHotT'($random(seed));
            select[s].activeListPtr = alIdxT'($random(seed));
        end
        stall = stallMode ? (($random(seed) & 3) == 0) : 1'b0;
        flushIqEntry = maskMode ? iqOneHotT'($random(seed)) : '0;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Run stopped: cycle limit reached before the tests finished");
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic finishTest(string name, int errBefore);
        testsRun++;
        if (errCount != errBefore) begin
            testsFailed++;
            $display("Test %s failed with %0d errors", name, errCount - errBefore);
        end else begin
            $display("Test %s ok", name);
        end
    endtask

    task automatic idle(int n);
        driveOps = 0;
        stallMode = 0;
        maskMode = 0;
        repeat (n) @(negedge clk);
    endtask

    task automatic expectOkay(string what, logic [1:0] resp);
        assert (resp == RespOkay) else reportValue(what, 0, resp, RespOkay);
    endtask

    // Selective recovery over one range, status read right after and later
    task automatic selectiveRun(int head, int tail, int all);
        logic [1:0] resp;
        logic [31:0] data;
        driveOps = 1;
        axiWrite(RegFlushHead, head, resp);
        axiWrite(RegFlushTail, tail, resp);
        axiWrite(RegFlushAll, all, resp);
        axiWrite(RegControl, 32'h1, resp);
        expectOkay("bresp", resp);
        @(negedge clk);
        axiRead(RegStatus, data, resp);
        assert (data == 32'd1) else reportValue("RegStatus", 0, data, 1);
        repeat (4) @(negedge clk);
        axiRead(RegStatus, data, resp);
        assert (data == 32'd0) else reportValue("RegStatus", 0, data, 0);
        idle(4);
    endtask

    initial begin
        int errBefore;
        logic [1:0] resp;
        logic [31:0] data;
        rstN = 1'b0;
        stall = 1'b0;
        select = '0;
        flushIqEntry = '0;
        axiReq = '0;
        axiReq.bready = 1'b1;
        axiReq.rready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        errBefore = errCount;
        driveOps = 1;
        repeat (40) @(negedge clk);
        idle(4);
        finishTest("latency", errBefore);

        errBefore = errCount;
        driveOps = 1;
        maskMode = 1;
        repeat (40) @(negedge clk);
        idle(4);
        finishTest("selection mask", errBefore);

        errBefore = errCount;
        driveOps = 1;
        stallMode = 1;
        repeat (60) @(negedge clk);
        idle(4);
        finishTest("stall", errBefore);

        errBefore = errCount;
        driveOps = 1;
        axiWrite(RegControl, 32'h2, resp);
        expectOkay("bresp", resp);
        repeat (5) @(negedge clk);
        axiWrite(RegControl, 32'h3, resp);
        idle(4);
        finishTest("full recovery", errBefore);

        errBefore = errCount;
        selectiveRun(3, 10, 0);
        selectiveRun(12, 4, 0);
        selectiveRun(5, 5, 1);
        finishTest("selective recovery", errBefore);

        errBefore = errCount;
        axiWrite(RegFlushHead, 32'h9, resp);
        axiWrite(RegFlushTail, 32'h2, resp);
        axiWrite(RegFlushAll, 32'h0, resp);
        axiRead(RegFlushHead, data, resp);
        assert (data == 32'h9) else reportValue("RegFlushHead", 0, data, 9);
        expectOkay("rresp", resp);
        axiRead(RegFlushTail, data, resp);
        assert (data == 32'h2) else reportValue("RegFlushTail", 0, data, 2);
        axiRead(RegFlushAll, data, resp);
        assert (data == 32'h0) else reportValue("RegFlushAll", 0, data, 0);
        axiRead(8'h40, data, resp);
        assert (resp == RespSlvErr) else reportValue("rresp", 0, resp, RespSlvErr);
        axiWrite(8'h40, 32'h1, resp);
        assert (resp == RespSlvErr) else reportValue("bresp", 0, resp, RespSlvErr);
        finishTest("register access", errBefore);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: wakeupSched.f
+incdir+verification
rtl/wakeupPkg.sv
rtl/wakeupLane.sv
rtl/recoveryRegs.sv
rtl/wakeupSched.sv
verification/wakeupTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= wakeupTb
FILELIST  ?= wakeupSched.f
OBJ       ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "No pass message"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)
